//--- hw/exu_alu.sv
`timescale 1ns/1ns

module exu_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  exu_pkg::alu_req_t req_i,
    input  logic              wb_ready_i,
    input  logic              int_assert_i,
    input  logic              misaligned_fetch_i,
    output exu_pkg::wb_t      wb_o,
    output logic              stall_o
);

    import riscv_pkg::*;
    import exu_pkg::*;

    // last accepted result, source for forwarding
    logic [XLEN-1:0] last_result_q;

    // mirror a word end to end
    function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    // forwarding muxes
    wire [XLEN-1:0] mux_op1 = req_i.pass_op1 ? last_result_q : req_i.op1;
    wire [XLEN-1:0] mux_op2 = req_i.pass_op2 ? last_result_q : req_i.op2;

    // one-hot views of the op
    wire op_add   = (req_i.alu_op == ALU_ADD);
    wire op_sub   = (req_i.alu_op == ALU_SUB);
    wire op_sll   = (req_i.alu_op == ALU_SLL);
    wire op_slt   = (req_i.alu_op == ALU_SLT);
    wire op_sltu  = (req_i.alu_op == ALU_SLTU);
    wire op_xor   = (req_i.alu_op == ALU_XOR);
    wire op_srl   = (req_i.alu_op == ALU_SRL);
    wire op_sra   = (req_i.alu_op == ALU_SRA);
    wire op_or    = (req_i.alu_op == ALU_OR);
    wire op_and   = (req_i.alu_op == ALU_AND);
    wire op_lui   = (req_i.alu_op == ALU_LUI);
    wire op_auipc = (req_i.alu_op == ALU_AUIPC);
    wire op_jump  = (req_i.alu_op == ALU_JUMP);

    // groups sharing a unit
    wire op_right   = op_srl | op_sra;
    wire op_shift   = op_sll | op_right;
    wire op_compare = op_slt | op_sltu;
    wire op_adder   = op_add | op_sub | op_compare | op_auipc | op_jump;
    // subtract path: a + ~b + 1
    wire op_invert  = op_sub | op_compare;

    ////////////////////////////////////////
    // shifter
    ////////////////////////////////////////

    // right shifts go through the left shifter reversed
    wire [XLEN-1:0] shift_in  = {XLEN{op_shift}} &
                                (op_right ? bit_rev(mux_op1) : mux_op1);
    wire [4:0]      shamt     = {5{op_shift}} & mux_op2[4:0];
    wire [XLEN-1:0] shift_res = shift_in << shamt;

    wire [XLEN-1:0] sll_res   = shift_res;
    wire [XLEN-1:0] srl_res   = bit_rev(shift_res);
    // top shamt bits take the sign
    wire [XLEN-1:0] sra_mask  = ~({XLEN{1'b1}} >> shamt);
    wire [XLEN-1:0] sra_res   = (srl_res & ~sra_mask) | ({XLEN{mux_op1[XLEN-1]}} & sra_mask);

    ////////////////////////////////////////
    // shared adder
    ////////////////////////////////////////

    wire [XLEN-1:0] adder_a   = {XLEN{op_adder}} & mux_op1;
    wire [XLEN-1:0] adder_b   = {XLEN{op_adder}} & (op_invert ? ~mux_op2 : mux_op2);
    wire            adder_cin = op_adder & op_invert;
    // bit 32 is the carry out
    wire [XLEN:0]   adder_res = {1'b0, adder_a} + {1'b0, adder_b} + {{XLEN{1'b0}}, adder_cin};

    ////////////////////////////////////////
    // compare
    ////////////////////////////////////////

    // mixed signs decide directly, else sign of the difference
    wire signs_differ   = mux_op1[XLEN-1] ^ mux_op2[XLEN-1];
    wire lt_signed      = signs_differ ? mux_op1[XLEN-1] : adder_res[XLEN-1];
    // no carry out means a borrow
    wire lt_unsigned    = ~adder_res[XLEN];

    ////////////////////////////////////////
    // result select
    ////////////////////////////////////////

    // dropped when not valid or under interrupt
    wire            res_en  = req_i.valid & ~int_assert_i;
    wire [XLEN-1:0] alu_res = {XLEN{res_en}} & (
        ({XLEN{op_add | op_sub | op_auipc | op_jump}} & adder_res[XLEN-1:0]) |
        ({XLEN{op_xor}}  & (mux_op1 ^ mux_op2)) |
        ({XLEN{op_or}}   & (mux_op1 | mux_op2)) |
        ({XLEN{op_and}}  & (mux_op1 & mux_op2)) |
        ({XLEN{op_sll}}  & sll_res) |
        ({XLEN{op_srl}}  & srl_res) |
        ({XLEN{op_sra}}  & sra_res) |
        ({XLEN{op_slt}}  & {{(XLEN-1){1'b0}}, lt_signed}) |
        ({XLEN{op_sltu}} & {{(XLEN-1){1'b0}}, lt_unsigned}) |
        ({XLEN{op_lui}}  & mux_op2));

    // write port
    assign wb_o.we        = req_i.valid & req_i.reg_we & ~int_assert_i;
    assign wb_o.waddr     = (int_assert_i | misaligned_fetch_i) ? '0 : req_i.rd;
    assign wb_o.data      = alu_res;
    assign wb_o.commit_id = req_i.commit_id;

    // write held off by the consumer
    assign stall_o = wb_o.we & ~wb_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_result_q <= '0;
        end else if (wb_o.we & wb_ready_i) begin
            last_result_q <= alu_res;
        end
    end

endmodule

//--- hw/exu_alu_dec.sv
`timescale 1ns/1ns

module exu_alu_dec (
    input  exu_pkg::issue_t issue_i,
    output exu_pkg::dec_t   dec_o
);

    import riscv_pkg::*;
    import exu_pkg::*;

    // register-register form, only place where funct7_5 means sub
    wire is_op = (issue_i.opcode == OP);

    always_comb begin
        // illegal or unsupported opcode falls through as a no-op
        dec_o.alu_op  = ALU_NONE;
        dec_o.op1_sel = OP1_RS1;
        dec_o.op2_sel = OP2_RS2;
        dec_o.reg_we  = 1'b0;

        case (issue_i.opcode)
            OP, OP_IMM: begin
                dec_o.op2_sel = is_op ? OP2_RS2 : OP2_IMM;
                dec_o.reg_we  = 1'b1;
                case (issue_i.funct3)
                    // addi has no subtract form
                    F3_ADD_SUB: dec_o.alu_op = (is_op && issue_i.funct7_5) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec_o.alu_op = ALU_SLL;
                    F3_SLT:     dec_o.alu_op = ALU_SLT;
                    F3_SLTU:    dec_o.alu_op = ALU_SLTU;
                    F3_XOR:     dec_o.alu_op = ALU_XOR;
                    // srai carries the same bit in imm[10]
                    F3_SRL_SRA: dec_o.alu_op = issue_i.funct7_5 ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec_o.alu_op = ALU_OR;
                    F3_AND:     dec_o.alu_op = ALU_AND;
                    default:    dec_o.alu_op = ALU_NONE;
                endcase
            end
            LUI: begin
                dec_o.alu_op  = ALU_LUI;
                dec_o.op2_sel = OP2_IMM;
                dec_o.reg_we  = 1'b1;
            end
            AUIPC: begin
                dec_o.alu_op  = ALU_AUIPC;
                dec_o.op1_sel = OP1_PC;
                dec_o.op2_sel = OP2_IMM;
                dec_o.reg_we  = 1'b1;
            end
            JAL, JALR: begin
                // link value pc+4, target is not computed here
                dec_o.alu_op  = ALU_JUMP;
                dec_o.op1_sel = OP1_PC;
                dec_o.op2_sel = OP2_FOUR;
                dec_o.reg_we  = 1'b1;
            end
            default: begin
                dec_o.alu_op = ALU_NONE;
                dec_o.reg_we = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/exu_opnd.sv
`timescale 1ns/1ns

module exu_opnd (
    input  exu_pkg::issue_t                      issue_i,
    input  exu_pkg::dec_t                        dec_i,
    output logic [riscv_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
    output logic [riscv_pkg::REG_ADDR_W-1:0]     rs2_addr_o,
    input  logic [riscv_pkg::XLEN-1:0]           rs1_data_i,
    input  logic [riscv_pkg::XLEN-1:0]           rs2_data_i,
    input  logic                                 pend_valid_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0]     pend_rd_i,
    output exu_pkg::alu_req_t                    req_o
);

    import riscv_pkg::*;
    import exu_pkg::*;

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic            pass_op1;
    logic            pass_op2;

    // read ports straight from the instruction fields
    assign rs1_addr_o = issue_i.rs1;
    assign rs2_addr_o = issue_i.rs2;

    ////////////////////////////////////////
    // operand muxes
    ////////////////////////////////////////

    assign op1 = (dec_i.op1_sel == OP1_PC) ? issue_i.pc : rs1_data_i;

    always_comb begin
        case (dec_i.op2_sel)
            OP2_RS2:  op2 = rs2_data_i;
            OP2_IMM:  op2 = issue_i.imm;
            // link offset for jal/jalr
            OP2_FOUR: op2 = XLEN'(4);
            default:  op2 = '0;
        endcase
    end

    ////////////////////////////////////////
    // forwarding flags
    ////////////////////////////////////////

    // pending write not yet in the array, x0 never forwarded
    assign pass_op1 = (dec_i.op1_sel == OP1_RS1) && pend_valid_i &&
                      (pend_rd_i == issue_i.rs1) && (pend_rd_i != '0);
    assign pass_op2 = (dec_i.op2_sel == OP2_RS2) && pend_valid_i &&
                      (pend_rd_i == issue_i.rs2) && (pend_rd_i != '0);

    // pack the request for the alu
    always_comb begin
        req_o.valid     = issue_i.valid;
        req_o.alu_op    = dec_i.alu_op;
        req_o.op1       = op1;
        req_o.op2       = op2;
        req_o.pass_op1  = pass_op1;
        req_o.pass_op2  = pass_op2;
        req_o.rd        = issue_i.rd;
        req_o.reg_we    = dec_i.reg_we;
        req_o.commit_id = issue_i.commit_id;
    end

endmodule

//--- hw/exu_pkg.sv
package exu_pkg;

    import riscv_pkg::*;

    ////////////////////////////////////////
    // operation and operand selects
    ////////////////////////////////////////

    // alu function, none means no result
    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_AUIPC,
        ALU_JUMP
    } alu_op_e;

    // first operand source
    typedef enum logic {
        OP1_RS1,
        OP1_PC
    } op1_sel_e;

    // second operand source, four for link address
    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM,
        OP2_FOUR
    } op2_sel_e;

    ////////////////////////////////////////
    // block to block bundles
    ////////////////////////////////////////

    // instruction as handed over by issue
    typedef struct packed {
        logic                   valid;
        logic [6:0]             opcode;
        logic [2:0]             funct3;
        logic                   funct7_5;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        imm;
        logic [XLEN-1:0]        pc;
        logic [COMMIT_ID_W-1:0] commit_id;
    } issue_t;

    // decoder result
    typedef struct packed {
        alu_op_e  alu_op;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        logic     reg_we;
    } dec_t;

    // collected operands plus forwarding flags
    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        logic [XLEN-1:0]        op1;
        logic [XLEN-1:0]        op2;
        logic                   pass_op1;
        logic                   pass_op2;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   reg_we;
        logic [COMMIT_ID_W-1:0] commit_id;
    } alu_req_t;

    // write port towards the register file
    typedef struct packed {
        logic                   we;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [XLEN-1:0]        data;
        logic [COMMIT_ID_W-1:0] commit_id;
    } wb_t;

endpackage

//--- hw/exu_regfile.sv
`timescale 1ns/1ns

module exu_regfile (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [riscv_pkg::REG_ADDR_W-1:0]     rs1_addr_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0]     rs2_addr_i,
    output logic [riscv_pkg::XLEN-1:0]           rs1_data_o,
    output logic [riscv_pkg::XLEN-1:0]           rs2_data_o,
    input  exu_pkg::wb_t                         wb_i,
    input  logic                                 wb_ready_i,
    output logic                                 pend_valid_o,
    output logic [riscv_pkg::REG_ADDR_W-1:0]     pend_rd_o
);

    import riscv_pkg::*;

    // x1..x31, x0 is not stored
    logic [XLEN-1:0]       regs_q [1:31];
    logic                  pend_valid_q;
    logic [REG_ADDR_W-1:0] pend_rd_q;
    logic [XLEN-1:0]       pend_data_q;

    // write handshake completes
    wire wb_accept = wb_i.we & wb_ready_i;

    ////////////////////////////////////////
    // pending write stage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid_q <= 1'b0;
            pend_rd_q    <= '0;
        end else begin
            // one entry, drains every cycle
            pend_valid_q <= wb_accept;
            if (wb_accept) begin
                pend_rd_q <= wb_i.waddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_accept) begin
            pend_data_q <= wb_i.data;
        end
    end

    ////////////////////////////////////////
    // architectural array
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (pend_valid_q && (pend_rd_q != '0)) begin
            // lands one edge after acceptance
            regs_q[pend_rd_q] <= pend_data_q;
        end
    end

    // x0 reads zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    assign pend_valid_o = pend_valid_q;
    assign pend_rd_o    = pend_rd_q;

endmodule

//--- hw/exu_top.sv
`timescale 1ns/1ns

module exu_top (
    input  logic            clk,
    input  logic            rst_n,
    input  exu_pkg::issue_t issue_i,
    input  logic            wb_ready_i,
    input  logic            int_assert_i,
    input  logic            misaligned_fetch_i,
    output exu_pkg::wb_t    wb_o,
    output logic            stall_o
);

    import riscv_pkg::*;
    import exu_pkg::*;

    dec_t                  dec;
    alu_req_t              alu_req;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    // pending write seen by the operand collector
    logic                  pend_valid;
    logic [REG_ADDR_W-1:0] pend_rd;

    ////////////////////////////////////////
    // decode and operand collect
    ////////////////////////////////////////

    exu_alu_dec u_alu_dec (
        .issue_i (issue_i),
        .dec_o   (dec)
    );

    exu_opnd u_opnd (
        .issue_i      (issue_i),
        .dec_i        (dec),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .pend_valid_i (pend_valid),
        .pend_rd_i    (pend_rd),
        .req_o        (alu_req)
    );

    // written from the alu port after the handshake
    exu_regfile u_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .wb_i         (wb_o),
        .wb_ready_i   (wb_ready_i),
        .pend_valid_o (pend_valid),
        .pend_rd_o    (pend_rd)
    );

    ////////////////////////////////////////
    // execute
    ////////////////////////////////////////

    exu_alu u_alu (
        .clk                (clk),
        .rst_n              (rst_n),
        .req_i              (alu_req),
        .wb_ready_i         (wb_ready_i),
        .int_assert_i       (int_assert_i),
        .misaligned_fetch_i (misaligned_fetch_i),
        .wb_o               (wb_o),
        .stall_o            (stall_o)
    );

endmodule

//--- hw/riscv_pkg.sv
package riscv_pkg;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////

    // integer register width
    localparam int XLEN        = 32;
    // x0..x31
    localparam int REG_ADDR_W  = 5;
    // tag that follows an instruction to commit
    localparam int COMMIT_ID_W = 3;

    ////////////////////////////////////////
    // major opcodes
    ////////////////////////////////////////

    // only the integer classes this slice executes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    ////////////////////////////////////////
    // funct3 for OP / OP_IMM
    ////////////////////////////////////////

    // add or sub, picked by funct7 bit 5
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    // srl or sra, picked by funct7 bit 5
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

//--- run.sh
#!/usr/bin/env bash
# build and run the execute slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module exu_tb \
    -f sim.f \
    -o Vexu_tb

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/Vexu_tb

//--- sim.f
hw/riscv_pkg.sv
hw/exu_pkg.sv
hw/exu_alu_dec.sv
hw/exu_opnd.sv
hw/exu_regfile.sv
hw/exu_alu.sv
hw/exu_top.sv
tests/exu_tb.sv

//--- tests/exu_tb.sv
`timescale 1ns/1ns

module exu_tb;

    import riscv_pkg::*;
    import exu_pkg::*;

    localparam int N_ROUNDS  = 12;
    // reset reads, rounds of 22, directed tail
    localparam int N_INSTR   = 31 + N_ROUNDS * 22 + 80;
    localparam int STALL_MAX = 6;

    logic        clk;
    logic        rst_n;
    issue_t      issue;
    logic        wb_ready;
    logic        int_assert;
    logic        misaligned;
    wb_t         wb;
    logic        stall;
    // reference register state
    logic [31:0] shadow [0:31];
    logic [31:0] pc;
    logic [2:0]  cid;
    // stall level the model predicts for the current cycle
    logic        exp_stall;

    exu_top dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .issue_i            (issue),
        .wb_ready_i         (wb_ready),
        .int_assert_i       (int_assert),
        .misaligned_fetch_i (misaligned),
        .wb_o               (wb),
        .stall_o            (stall)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    // stall level must follow the write handshake
    stall_follows_we: assert property (@(posedge clk) disable iff (!rst_n)
        stall == exp_stall)
    else begin
        $display("error: t=%0t stall_o got %b expected %b", $time,
                 $sampled(stall), $sampled(exp_stall));
        stop_on_error();
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic writes_reg(input logic [6:0] opc);
        return (opc == OP) || (opc == OP_IMM) || (opc == LUI) ||
               (opc == AUIPC) || (opc == JAL) || (opc == JALR);
    endfunction

    // rv32i result from the spec rules
    function automatic logic [31:0] model_result(input logic [6:0] opc, input logic [2:0] f3,
                                                 input logic f7, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [31:0] pc_v);
        logic [31:0] r;
        logic [4:0]  sh;
        r  = '0;
        sh = b[4:0];
        if ((opc == OP) || (opc == OP_IMM)) begin
            case (f3)
                3'b000: r = ((opc == OP) && f7) ? a - b : a + b;
                3'b001: r = a << sh;
                3'b010: r = {31'b0, $signed(a) < $signed(b)};
                3'b011: r = {31'b0, a < b};
                3'b100: r = a ^ b;
                3'b101: begin
                    if (f7) r = $signed(a) >>> sh;
                    else    r = a >> sh;
                end
                3'b110: r = a | b;
                default: r = a & b;
            endcase
        end else if (opc == LUI) begin
            r = b;
        end else if (opc == AUIPC) begin
            r = pc_v + b;
        end else if ((opc == JAL) || (opc == JALR)) begin
            // link address
            r = pc_v + 32'd4;
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic check_wb(input logic exp_we, input logic [4:0] exp_addr,
                            input logic [31:0] exp_data);
        check_val("wb_o.we", 32'(wb.we), 32'(exp_we));
        check_val("wb_o.waddr", 32'(wb.waddr), 32'(exp_addr));
        check_val("wb_o.data", wb.data, exp_data);
        check_val("wb_o.commit_id", 32'(wb.commit_id), 32'(cid));
    endtask

    // issue one instruction, ready held low for n_stall cycles
    task automatic exec(input logic [6:0] opc, input logic [2:0] f3, input logic f7,
                        input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                        input logic [31:0] imm, input int n_stall, input logic intr,
                        input logic mis);
        logic [31:0] b;
        logic [31:0] res;
        logic        exp_we;
        logic [4:0]  exp_addr;
        @(negedge clk);
        issue      = '{valid: 1'b1, opcode: opc, funct3: f3, funct7_5: f7, rs1: rs1,
                       rs2: rs2, rd: rd, imm: imm, pc: pc, commit_id: cid};
        wb_ready   = (n_stall == 0);
        int_assert = intr;
        misaligned = mis;
        b        = (opc == OP) ? shadow[rs2] : imm;
        res      = intr ? 32'd0 : model_result(opc, f3, f7, shadow[rs1], b, pc);
        exp_we   = writes_reg(opc) && !intr;
        exp_addr = (intr || mis) ? 5'd0 : rd;
        exp_stall = exp_we && (n_stall != 0);
        #1;
        check_wb(exp_we, exp_addr, res);
        for (int k = 1; k <= n_stall; k++) begin
            check_val("stall_o", 32'(stall), 32'(exp_we));
            @(posedge clk);
            @(negedge clk);
            if (k == n_stall) begin
                wb_ready  = 1'b1;
                exp_stall = 1'b0;
            end
            #1;
            // held result
            check_wb(exp_we, exp_addr, res);
        end
        @(posedge clk);
        if (exp_we && (exp_addr != 5'd0)) shadow[exp_addr] = res;
        pc  = pc + 32'd4;
        cid = cid + 3'd1;
    endtask

    task automatic op_rr(input logic [2:0] f3, input logic f7, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        exec(OP, f3, f7, rs1, rs2, rd, 32'd0, 0, 1'b0, 1'b0);
    endtask

    task automatic op_ri(input logic [2:0] f3, input logic f7, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [31:0] imm);
        exec(OP_IMM, f3, f7, rs1, 5'd0, rd, imm, 0, 1'b0, 1'b0);
    endtask

    // addi r, r, 0 shows the current value on wb_o
    task automatic read_reg(input logic [4:0] r);
        op_ri(F3_ADD_SUB, 1'b0, r, r, 32'd0);
    endtask

    // lui then addi, the addi forwards from the lui
    task automatic load_reg(input logic [4:0] r, input logic [31:0] val);
        logic [19:0] hi;
        hi = val[31:12] + 20'(val[11]);
        exec(LUI, 3'd0, 1'b0, 5'd0, 5'd0, r, {hi, 12'b0}, 0, 1'b0, 1'b0);
        op_ri(F3_ADD_SUB, 1'b0, r, r, {{20{val[11]}}, val[11:0]});
    endtask

    function automatic logic [4:0] pick_reg(input logic [4:0] x, input logic [4:0] y);
        logic [4:0] r;
        r = 5'($urandom_range(31, 1));
        while ((r == x) || (r == y)) r = 5'($urandom_range(31, 1));
        return r;
    endfunction

    function automatic logic [31:0] simm12();
        logic [11:0] v;
        v = 12'($urandom);
        return {{20{v[11]}}, v};
    endfunction

    ////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////

    initial begin
        repeat (N_INSTR * 4 + 100) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] va;
        logic [31:0] vb;
        void'($urandom(32'ha874_19e1));
        clk        = 1'b0;
        rst_n      = 1'b0;
        issue      = '0;
        wb_ready   = 1'b1;
        int_assert = 1'b0;
        misaligned = 1'b0;
        pc         = 32'h0000_1000;
        cid        = '0;
        exp_stall  = 1'b0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;

        // outputs quiet in reset
        repeat (5) begin
            @(negedge clk);
            check_val("wb_o.we", 32'(wb.we), 32'd0);
            check_val("stall_o", 32'(stall), 32'd0);
        end
        rst_n = 1'b1;
        for (int i = 1; i < 32; i++) read_reg(5'(i));

        // all ops on random operands
        for (int n = 0; n < N_ROUNDS; n++) begin
            ra = 5'($urandom_range(31, 1));
            rb = pick_reg(ra, ra);
            va = $urandom;
            vb = $urandom;
            // mixed signs on odd rounds
            if (n % 2 == 1) begin
                va[31] = 1'b1;
                vb[31] = 1'b0;
            end
            load_reg(ra, va);
            load_reg(rb, vb);
            for (int f = 0; f < 8; f++) op_rr(3'(f), 1'b0, pick_reg(ra, rb), ra, rb);
            op_rr(F3_ADD_SUB, 1'b1, pick_reg(ra, rb), ra, rb);
            op_rr(F3_SRL_SRA, 1'b1, pick_reg(ra, rb), ra, rb);
            op_ri(F3_ADD_SUB, 1'b0, pick_reg(ra, rb), ra, simm12());
            op_ri(F3_SLT, 1'b0, pick_reg(ra, rb), ra, simm12());
            op_ri(F3_SLTU, 1'b0, pick_reg(ra, rb), ra, simm12());
            op_ri(F3_SLL, 1'b0, pick_reg(ra, rb), ra, 32'($urandom_range(31, 0)));
            op_ri(F3_SRL_SRA, 1'b0, pick_reg(ra, rb), ra, 32'($urandom_range(31, 0)));
            op_ri(F3_SRL_SRA, 1'b1, pick_reg(ra, rb), ra, 32'h400 | 32'($urandom_range(31, 0)));
            exec(AUIPC, 3'd0, 1'b0, 5'd0, 5'd0, pick_reg(ra, rb), {20'($urandom), 12'b0},
                 0, 1'b0, 1'b0);
            exec(JAL, 3'd0, 1'b0, 5'd0, 5'd0, pick_reg(ra, rb), 32'd0, 0, 1'b0, 1'b0);
        end

        // forwarding in both operand slots, x0 never forwarded
        load_reg(5'd5, $urandom);
        op_rr(F3_ADD_SUB, 1'b0, 5'd6, 5'd5, 5'd0);
        load_reg(5'd9, $urandom);
        op_rr(F3_ADD_SUB, 1'b1, 5'd7, 5'd0, 5'd9);
        op_rr(F3_OR, 1'b0, 5'd8, 5'd0, 5'd0);
        op_ri(F3_ADD_SUB, 1'b0, 5'd0, 5'd5, 32'd1);
        op_rr(F3_ADD_SUB, 1'b0, 5'd10, 5'd0, 5'd0);
        exec(JALR, 3'd0, 1'b0, 5'd1, 5'd0, 5'd11, 32'd8, 0, 1'b0, 1'b0);

        // back-pressure, accepted once when ready returns
        for (int s = 0; s < 4; s++) begin
            load_reg(5'd12, $urandom);
            exec(OP, F3_XOR, 1'b0, 5'd12, 5'd9, 5'd13, 32'd0,
                 $urandom_range(STALL_MAX, 1), 1'b0, 1'b0);
            read_reg(5'd13);
        end

        // interrupt drops the write
        exec(OP, F3_ADD_SUB, 1'b0, 5'd5, 5'd9, 5'd14, 32'd0, 0, 1'b1, 1'b0);
        read_reg(5'd14);
        exec(OP_IMM, F3_OR, 1'b0, 5'd9, 5'd0, 5'd9, simm12(), 2, 1'b1, 1'b0);
        read_reg(5'd9);

        // misaligned fetch steers to x0
        exec(OP, F3_AND, 1'b0, 5'd5, 5'd9, 5'd15, 32'd0, 0, 1'b0, 1'b1);
        read_reg(5'd15);
        exec(LUI, 3'd0, 1'b0, 5'd0, 5'd0, 5'd5, 32'hdead_b000, 0, 1'b0, 1'b1);
        read_reg(5'd5);

        // opcode outside the slice is a no-op
        exec(7'b0000011, 3'd2, 1'b0, 5'd5, 5'd0, 5'd16, 32'd4, 0, 1'b0, 1'b0);
        read_reg(5'd16);

        @(negedge clk);
        issue.valid = 1'b0;
        int_assert  = 1'b0;
        misaligned  = 1'b0;
        repeat (2) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule
